//--- Bender.yml
package:
  name: pipeline_core

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/hazard_unit.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/memory_stage.sv
      - rtl/pipeline_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/pipeline_core_tb.sv

//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;

	// datapath and address widths
	localparam int word_w = 16;
	localparam int reg_w = 3;
	localparam int op_w = 4;
	localparam int imem_aw = 8;
	localparam int dmem_aw = 8;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_w-1:0] reg_idx_t;
	typedef logic [op_w-1:0] opcode_t;
	typedef logic [imem_aw-1:0] imem_addr_t;
	typedef logic [dmem_aw-1:0] dmem_addr_t;

	// opcodes of the reduced set
	localparam opcode_t op_adi = 4'b0000;
	localparam opcode_t op_add = 4'b0001;
	localparam opcode_t op_ndu = 4'b0010;
	localparam opcode_t op_lhi = 4'b0011;
	localparam opcode_t op_lw = 4'b0100;
	localparam opcode_t op_sw = 4'b0101;
	localparam opcode_t op_beq = 4'b1000;
	localparam opcode_t op_jal = 4'b1001;

	// lsb of each instruction field
	localparam int op_lsb = 12;
	localparam int ra_lsb = 9;
	localparam int rb_lsb = 6;
	localparam int rc_lsb = 3;
	// immediates sit at bit 0
	localparam int imm6_w = 6;
	localparam int imm9_w = 9;

	// bubble, an ADD with the unused low bits set
	// decode recognises the whole word and drops its write
	localparam word_t nop_instr = {op_add, 12'h007};

	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;

	// LHI places imm9 above this many zero bits
	localparam int lhi_shift = 7;

endpackage

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic stall,
	input wire logic flush_ex,
	input wire word_t if_pc,
	input wire word_t if_instr,
	input wire logic wb_valid,
	input wire reg_idx_t wb_reg,
	input wire word_t wb_data,
	output reg_idx_t id_rs1,
	output reg_idx_t id_rs2,
	output logic id_uses_rs1,
	output logic id_uses_rs2,
	output logic id_redirect,
	output word_t id_target,
	output word_t ex_pc,
	output word_t ex_instr,
	output word_t ex_a,
	output word_t ex_b,
	output reg_idx_t ex_rs1,
	output reg_idx_t ex_rs2,
	output reg_idx_t ex_rd,
	output opcode_t ex_op,
	output logic ex_wr
);

	word_t rf [2**reg_w];
	opcode_t op;
	reg_idx_t ra;
	reg_idx_t rb;
	reg_idx_t rc;
	reg_idx_t rd;
	logic wr;
	word_t rs1_val;
	word_t rs2_val;
	word_t imm9_sext;

	// instruction fields
	assign op = if_instr[op_lsb +: op_w];
	assign ra = if_instr[ra_lsb +: reg_w];
	assign rb = if_instr[rb_lsb +: reg_w];
	assign rc = if_instr[rc_lsb +: reg_w];

	// sources, destination and write enable per opcode
	// loads and stores take the base from rb, SW data from ra
	always_comb begin
		id_rs1 = ra;
		id_rs2 = rb;
		id_uses_rs1 = 1'b0;
		id_uses_rs2 = 1'b0;
		rd = rc;
		wr = 1'b0;
		case (op)
			op_add, op_ndu: begin
				id_uses_rs1 = 1'b1;
				id_uses_rs2 = 1'b1;
				wr = 1'b1;
			end
			op_adi: begin
				id_uses_rs1 = 1'b1;
				rd = rb;
				wr = 1'b1;
			end
			op_lhi, op_jal: begin
				rd = ra;
				wr = 1'b1;
			end
			op_lw: begin
				id_rs1 = rb;
				id_uses_rs1 = 1'b1;
				rd = ra;
				wr = 1'b1;
			end
			op_sw: begin
				id_rs1 = rb;
				id_rs2 = ra;
				id_uses_rs1 = 1'b1;
				id_uses_rs2 = 1'b1;
			end
			op_beq: begin
				id_uses_rs1 = 1'b1;
				id_uses_rs2 = 1'b1;
			end
			default: wr = 1'b0;
		endcase
		// bubble never writes
		if (if_instr == nop_instr) begin
			wr = 1'b0;
		end
	end

	// register file, written from MEM/WB
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rf <= '{default: '0};
		end else if (wb_valid) begin
			rf[wb_reg] <= wb_data;
		end
	end

	// same-cycle write goes straight through to the read
	assign rs1_val = (wb_valid && wb_reg == id_rs1) ? wb_data : rf[id_rs1];
	assign rs2_val = (wb_valid && wb_reg == id_rs2) ? wb_data : rf[id_rs2];

	// JAL resolves here
	assign imm9_sext = {{(word_w - imm9_w){if_instr[imm9_w-1]}}, if_instr[imm9_w-1:0]};
	assign id_redirect = (op == op_jal);
	assign id_target = if_pc + imm9_sext;

	// ID/EX control, bubble on stall or flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_instr <= nop_instr;
			ex_op <= op_add;
			ex_rd <= '0;
			ex_wr <= 1'b0;
		end else if (stall || flush_ex) begin
			ex_instr <= nop_instr;
			ex_op <= op_add;
			ex_rd <= '0;
			ex_wr <= 1'b0;
		end else begin
			ex_instr <= if_instr;
			ex_op <= op;
			ex_rd <= rd;
			ex_wr <= wr;
		end
	end

	// ID/EX payload, JAL carries its link value in b
	always_ff @(posedge clk) begin
		ex_pc <= if_pc;
		ex_a <= rs1_val;
		ex_b <= (op == op_jal) ? (if_pc + 16'd1) : rs2_val;
		ex_rs1 <= id_rs1;
		ex_rs2 <= id_rs2;
	end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire word_t ex_pc,
	input wire word_t ex_instr,
	input wire word_t ex_a,
	input wire word_t ex_b,
	input wire reg_idx_t ex_rs1,
	input wire reg_idx_t ex_rs2,
	input wire reg_idx_t ex_rd,
	input wire opcode_t ex_op,
	input wire logic ex_wr,
	input wire logic wb_valid,
	input wire reg_idx_t wb_reg,
	input wire word_t wb_data,
	output logic ex_is_load,
	output logic ex_redirect,
	output word_t ex_target,
	output opcode_t mem_op,
	output reg_idx_t mem_rd,
	output logic mem_wr,
	output word_t mem_result,
	output word_t mem_store
);

	logic mem_fwd_ok;
	word_t a_fwd;
	word_t b_fwd;
	word_t imm6_sext;
	word_t lhi_val;
	word_t result;

	// a load in EX/MEM only holds its address, its data comes a cycle later
	assign mem_fwd_ok = mem_wr && (mem_op != op_lw);

	// youngest producer first
	assign a_fwd = (mem_fwd_ok && mem_rd == ex_rs1) ? mem_result :
		(wb_valid && wb_reg == ex_rs1) ? wb_data : ex_a;
	assign b_fwd = (mem_fwd_ok && mem_rd == ex_rs2) ? mem_result :
		(wb_valid && wb_reg == ex_rs2) ? wb_data : ex_b;

	assign imm6_sext = {{(word_w - imm6_w){ex_instr[imm6_w-1]}}, ex_instr[imm6_w-1:0]};
	assign lhi_val = word_t'(ex_instr[imm9_w-1:0]) << lhi_shift;

	// ALU and address adder
	always_comb begin
		case (ex_op)
			op_add: result = a_fwd + b_fwd;
			op_ndu: result = ~(a_fwd & b_fwd);
			op_adi, op_lw, op_sw: result = a_fwd + imm6_sext;
			op_lhi: result = lhi_val;
			// link value from decode, never forwarded
			op_jal: result = ex_b;
			default: result = a_fwd + b_fwd;
		endcase
	end

	// BEQ predicted not taken, corrected here
	assign ex_redirect = (ex_op == op_beq) && (a_fwd == b_fwd);
	assign ex_target = ex_pc + imm6_sext;

	// tells the hazard unit a load sits in execute
	assign ex_is_load = (ex_op == op_lw);

	// EX/MEM control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_op <= op_add;
			mem_rd <= '0;
			mem_wr <= 1'b0;
		end else begin
			mem_op <= ex_op;
			mem_rd <= ex_rd;
			mem_wr <= ex_wr;
		end
	end

	// EX/MEM payload
	// SW data rides in mem_store
	always_ff @(posedge clk) begin
		mem_result <= result;
		mem_store <= b_fwd;
	end

	// a retiring instruction never sees an unknown operand
	a_fwd_known: assert property (@(posedge clk) disable iff (!rst_n)
		ex_wr |-> !$isunknown({a_fwd, b_fwd}));

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import core_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic stall,
	input wire logic flush_id,
	input wire logic flush_ex,
	input wire logic id_redirect,
	input wire word_t id_target,
	input wire logic ex_redirect,
	input wire word_t ex_target,
	input wire logic imem_we,
	input wire imem_addr_t imem_addr,
	input wire word_t imem_wdata,
	output word_t if_pc,
	output word_t if_instr
);

	word_t pc;
	word_t next_pc;
	logic if_flush;
	word_t imem [imem_depth];

	// program store, only the load port writes it
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// older instruction wins, so the BEQ target beats the JAL target
	always_comb begin
		if (ex_redirect) begin
			next_pc = ex_target;
		end else if (id_redirect) begin
			next_pc = id_target;
		end else begin
			next_pc = pc + 16'd1;
		end
	end

	// pc starts at word 0, frozen during a load-use stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= next_pc;
		end
	end

	// a redirect out of execute clears IF/ID too
	assign if_flush = flush_id | (flush_ex & ~stall);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_instr <= nop_instr;
		end else if (if_flush) begin
			if_instr <= nop_instr;
		end else if (!stall) begin
			if_instr <= imem[imem_addr_t'(pc)];
		end
	end

	// pc travels with its instruction
	always_ff @(posedge clk) begin
		if (!stall) begin
			if_pc <= pc;
		end
	end

	// program loading happens only under reset
	a_load_in_reset: assert property (@(posedge clk) imem_we |-> !rst_n);

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import core_pkg::*; (
	input wire reg_idx_t id_rs1,
	input wire reg_idx_t id_rs2,
	input wire reg_idx_t ex_rd,
	input wire logic id_uses_rs1,
	input wire logic id_uses_rs2,
	input wire logic ex_is_load,
	input wire logic id_redirect,
	input wire logic ex_redirect,
	output logic stall,
	output logic flush_id,
	output logic flush_ex
);

	logic rs1_hit;
	logic rs2_hit;

	// only operands decode really reads count
	assign rs1_hit = id_uses_rs1 && (id_rs1 == ex_rd);
	assign rs2_hit = id_uses_rs2 && (id_rs2 == ex_rd);

	// load result not ready until MEM/WB, so wait one cycle
	assign stall = ex_is_load && (rs1_hit || rs2_hit);

	// JAL kills one younger slot, taken BEQ kills two
	assign flush_id = id_redirect || ex_redirect;
	// the stall also drops a bubble into ID/EX
	assign flush_ex = ex_redirect || stall;

	// a load and a BEQ cannot both be in execute
	always_comb begin
		a_no_stall_on_redirect: assert final (!(stall && ex_redirect));
	end

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import core_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire opcode_t mem_op,
	input wire reg_idx_t mem_rd,
	input wire logic mem_wr,
	input wire word_t mem_result,
	input wire word_t mem_store,
	output logic wb_valid,
	output reg_idx_t wb_reg,
	output word_t wb_data
);

	word_t dmem [dmem_depth];
	dmem_addr_t addr;
	word_t load_data;

	// word index from the low bits of the computed address
	assign addr = dmem_addr_t'(mem_result);
	assign load_data = dmem[addr];

	// data memory, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dmem <= '{default: '0};
		end else if (mem_op == op_sw) begin
			dmem[addr] <= mem_store;
		end
	end

	// MEM/WB strobe and destination
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_reg <= '0;
		end else begin
			wb_valid <= mem_wr;
			wb_reg <= mem_rd;
		end
	end

	// loaded word for LW, otherwise the ALU result
	always_ff @(posedge clk) begin
		wb_data <= (mem_op == op_lw) ? load_data : mem_result;
	end

endmodule

`default_nettype wire

//--- rtl/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core import core_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic imem_we,
	input wire imem_addr_t imem_addr,
	input wire word_t imem_wdata,
	output logic wb_valid,
	output reg_idx_t wb_reg,
	output word_t wb_data
);

	// IF/ID
	word_t if_pc;
	word_t if_instr;

	// decode to hazard unit and fetch
	reg_idx_t id_rs1;
	reg_idx_t id_rs2;
	logic id_uses_rs1;
	logic id_uses_rs2;
	logic id_redirect;
	word_t id_target;

	// ID/EX
	word_t ex_pc;
	word_t ex_instr;
	word_t ex_a;
	word_t ex_b;
	reg_idx_t ex_rs1;
	reg_idx_t ex_rs2;
	reg_idx_t ex_rd;
	opcode_t ex_op;
	logic ex_wr;

	// execute to hazard unit and fetch
	logic ex_is_load;
	logic ex_redirect;
	word_t ex_target;

	// EX/MEM
	opcode_t mem_op;
	reg_idx_t mem_rd;
	logic mem_wr;
	word_t mem_result;
	word_t mem_store;

	// hazard controls
	logic stall;
	logic flush_id;
	logic flush_ex;

	// port names match the nets above
	fetch_stage u_fetch (.*);
	decode_stage u_decode (.*);
	execute_stage u_execute (.*);
	memory_stage u_memory (.*);
	hazard_unit u_hazard (.*);

endmodule

`default_nettype wire

//--- tb.f
+incdir+tests
rtl/core_pkg.sv
rtl/hazard_unit.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipeline_core.sv
tests/pipeline_core_tb.sv

//--- tests/program_table.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

localparam int prog_len = 19;
localparam int exp_len = 11;

// program image, word i lands at instruction address i
word_t prog_words [prog_len] = '{
	// LHI R1 3, ADI R2 R1 5, ADD R3 R1 R2, NDU R4 R1 R3, ADI R5 R4 -2
	16'h3203, 16'h0285, 16'h1298, 16'h22E0, 16'h097E,
	// SW R3 at R1+2, LW R6 from R1+2, ADD R7 R6 R5 right behind the load
	16'h5642, 16'h4C42, 16'h1D78,
	// BEQ R1 R2 +3 not taken, ADI R1 R1 5, BEQ R1 R2 +3 taken
	16'h8283, 16'h0245, 16'h8283,
	// two LHI in the branch shadow, then ADD R4 R1 R2 at the target
	16'h3DFF, 16'h3FFF, 16'h12A0,
	// JAL R5 +3, two LHI never reached, ADD R3 R5 R4 at the target
	16'h9A03, 16'h3DFF, 16'h3FFF, 16'h1B18,
	// BEQ R0 R0 0 parks the core
	16'h8000
};

// destination and value of each retirement, in order
reg_idx_t exp_reg [exp_len] = '{
	3'd1, 3'd2, 3'd3, 3'd4, 3'd5,
	3'd6, 3'd7,
	3'd1, 3'd4,
	3'd5, 3'd3
};

// 3 << 7, plus 5, sum, nand, minus 2, loaded word, wrapped sum
// R1 bumped to match R2, then R1 + R2, JAL link 15 and link + R4
word_t exp_data [exp_len] = '{
	16'h0180, 16'h0185, 16'h0305, 16'hFEFF, 16'hFEFD,
	16'h0305, 16'h0202,
	16'h0185, 16'h030A,
	16'h000F, 16'h0319
};

`endif

//--- tests/pipeline_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core_tb import core_pkg::*; ();

	localparam int clk_period = 100;
	localparam int min_reset_cycles = 8;
	// quiet cycles expected once the core parks on its self-loop
	localparam int watch_cycles = 20;

	`include "program_table.svh"

	// reset must also cover the whole program load
	localparam int reset_cycles = (prog_len > min_reset_cycles) ? prog_len : min_reset_cycles;
	// roughly six cycles per instruction worst case, plus margin
	localparam int cycle_limit = reset_cycles + 6 * prog_len + 40;

	logic clk;
	logic rst_n;
	logic imem_we;
	imem_addr_t imem_addr;
	word_t imem_wdata;
	logic wb_valid;
	reg_idx_t wb_reg;
	word_t wb_data;
	int cycle_count = 0;

	pipeline_core u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	endtask

	// guards against a core that never retires or never parks
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			stop_with_failure();
		end
	end

	task automatic compare_reg(input string name, input int row, input reg_idx_t expected,
		input reg_idx_t actual);
		if (actual !== expected) begin
			$display("FAILED %s row %0d: expected %h, actual %h", name, row, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic match_word(input string name, input int row, input word_t expected,
		input word_t actual);
		if (actual !== expected) begin
			$display("FAILED %s row %0d: expected %h, actual %h", name, row, expected, actual);
			stop_with_failure();
		end
	endtask

	// no retirement may show up here
	task automatic expect_quiet(input string when);
		if (wb_valid !== 1'b0) begin
			$display("unexpected writeback to register %0d %s", wb_reg, when);
			stop_with_failure();
		end
	endtask

	// one word per falling edge while rst_n stays low
	task automatic load_program();
		for (int i = 0; i < reset_cycles; i++) begin
			@(negedge clk);
			expect_quiet("while reset was held");
			if (i < prog_len) begin
				imem_we = 1'b1;
				imem_addr = imem_addr_t'(i);
				imem_wdata = prog_words[i];
			end else begin
				imem_we = 1'b0;
			end
		end
		@(negedge clk);
		expect_quiet("while reset was held");
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		rst_n = 1'b1;
	endtask

	// strobe is registered on the rising edge, so read it mid-cycle
	task automatic wait_writeback();
		do begin
			@(negedge clk);
		end while (wb_valid !== 1'b1);
	endtask

	task automatic watch_for_strays();
		repeat (watch_cycles) begin
			@(negedge clk);
			expect_quiet("after the last expected writeback");
		end
	endtask

	initial begin
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;

		load_program();

		// every retirement in program order, skipped slots must not appear
		for (int row = 0; row < exp_len; row++) begin
			wait_writeback();
			compare_reg("wb_reg", row, exp_reg[row], wb_reg);
			match_word("wb_data", row, exp_data[row], wb_data);
		end

		// BEQ R0 R0 0 loops forever and writes nothing
		watch_for_strays();

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
